//--- src/l2_geom_pkg.sv
// L2 bank geometry
// Address, data and ID widths, cache shape and request queue sizing
`default_nettype none

package l2_geom_pkg;

  // Port-side widths
  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int ID_W      = 4;
  localparam int NUM_PORTS = 2;
  localparam int PORT_W    = 1;

  // Cache shape, one word per line
  localparam int NUM_SETS = 16;
  localparam int IDX_W    = 4;
  localparam int TAG_W    = ADDR_W - IDX_W;
  localparam int NUM_WAYS = 2;
  localparam int WAY_W    = 1;

  // Request queue
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = 2;
  localparam int CNT_W       = 3;

endpackage

`default_nettype wire

//--- src/l2_msg_pkg.sv
// L2 bank message formats
// Port requests and responses, queue entries, core completions, memory traffic
`default_nettype none

package l2_msg_pkg;

  // One word request from a port
  typedef struct packed {
    logic                           valid;
    logic                           we;
    logic [l2_geom_pkg::ID_W-1:0]   id;
    logic [l2_geom_pkg::ADDR_W-1:0] addr;
    logic [l2_geom_pkg::DATA_W-1:0] wdata;
  } port_req_t;

  // Response to a port, writes echo their data
  typedef struct packed {
    logic                           valid;
    logic [l2_geom_pkg::ID_W-1:0]   id;
    logic [l2_geom_pkg::DATA_W-1:0] rdata;
  } port_res_t;

  // Queued request tagged with its source port
  typedef struct packed {
    logic                           we;
    logic [l2_geom_pkg::ID_W-1:0]   id;
    logic [l2_geom_pkg::ADDR_W-1:0] addr;
    logic [l2_geom_pkg::DATA_W-1:0] wdata;
    logic [l2_geom_pkg::PORT_W-1:0] port;
  } queue_entry_t;

  // Completion leaving the core
  typedef struct packed {
    logic                           valid;
    logic [l2_geom_pkg::PORT_W-1:0] port;
    logic [l2_geom_pkg::ID_W-1:0]   id;
    logic [l2_geom_pkg::DATA_W-1:0] rdata;
  } core_res_t;

  // Memory access strobe
  typedef struct packed {
    logic                           valid;
    logic                           we;
    logic [l2_geom_pkg::ADDR_W-1:0] addr;
    logic [l2_geom_pkg::DATA_W-1:0] wdata;
  } mem_req_t;

  // Memory completion, also acks writes
  typedef struct packed {
    logic                           valid;
    logic [l2_geom_pkg::DATA_W-1:0] rdata;
  } mem_res_t;

endpackage

`default_nettype wire

//--- src/l2_req_queue.sv
// L2 request queue (decode stage)
// Takes up to two port requests per cycle into a FIFO tagged with the source port
`timescale 1ns/1ps
`default_nettype none

module l2_req_queue (
  input  wire logic                                               clk_i,
  input  wire logic                                               arst_n_i,
  input  wire l2_msg_pkg::port_req_t [l2_geom_pkg::NUM_PORTS-1:0] req_i,
  output logic [l2_geom_pkg::NUM_PORTS-1:0]                       rdy_o,
  output l2_msg_pkg::queue_entry_t                                head_o,
  output logic                                                    head_vld_o,
  input  wire logic                                               pop_i
);

  // ==============================
  // Storage and pointers
  // ==============================
  // Entry array, payload only
  l2_msg_pkg::queue_entry_t mem_q [l2_geom_pkg::QUEUE_DEPTH];

  logic [l2_geom_pkg::QPTR_W-1:0] head_q;
  logic [l2_geom_pkg::QPTR_W-1:0] tail_q;
  logic [l2_geom_pkg::CNT_W-1:0]  count_q;

  // Free slots from the registered count
  int free_slots;

  // Per-port accept and slot to write
  logic [l2_geom_pkg::NUM_PORTS-1:0]                         accept;
  logic [l2_geom_pkg::NUM_PORTS-1:0][l2_geom_pkg::QPTR_W-1:0] wr_ptr;
  logic [l2_geom_pkg::CNT_W-1:0]                             push_cnt;
  logic                                                      pop;

  assign free_slots = l2_geom_pkg::QUEUE_DEPTH - int'(count_q);

  // Port p needs p+1 free slots, so port 0 never loses a slot to port 1
  always_comb begin
    for (int p = 0; p < l2_geom_pkg::NUM_PORTS; p++) begin
      rdy_o[p] = (free_slots > p);
    end
  end

  // ==============================
  // Push side
  // ==============================
  // Accepted requests land in port order starting at the tail
  always_comb begin
    logic [l2_geom_pkg::QPTR_W-1:0] ptr;
    ptr      = tail_q;
    push_cnt = '0;
    for (int p = 0; p < l2_geom_pkg::NUM_PORTS; p++) begin
      accept[p] = req_i[p].valid && rdy_o[p];
      wr_ptr[p] = ptr;
      if (accept[p]) begin
        ptr      = ptr + 1'b1;
        push_cnt = push_cnt + 1'b1;
      end
    end
  end

  // Entry write, source port index kept with the request
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < l2_geom_pkg::NUM_PORTS; p++) begin
      if (accept[p]) begin
        mem_q[wr_ptr[p]].we    <= req_i[p].we;
        mem_q[wr_ptr[p]].id    <= req_i[p].id;
        mem_q[wr_ptr[p]].addr  <= req_i[p].addr;
        mem_q[wr_ptr[p]].wdata <= req_i[p].wdata;
        mem_q[wr_ptr[p]].port  <= p[l2_geom_pkg::PORT_W-1:0];
      end
    end
  end

  // ==============================
  // Pop side and count
  // ==============================
  assign head_vld_o = (count_q != '0);
  assign head_o     = mem_q[head_q];

  // Ignore a pop on an empty queue
  assign pop = pop_i && head_vld_o;

  // Push and pop may share a cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      tail_q  <= tail_q + push_cnt[l2_geom_pkg::QPTR_W-1:0];
      count_q <= count_q + push_cnt - {{(l2_geom_pkg::CNT_W-1){1'b0}}, pop};
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/l2_cache_core.sv
// L2 cache core (execute stage)
// Blocking 2-way write-through cache, one LRU bit per set, one memory access in flight
`timescale 1ns/1ps
`default_nettype none

module l2_cache_core (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,
  input  wire l2_msg_pkg::queue_entry_t head_i,
  input  wire logic                     head_vld_i,
  output logic                          pop_o,
  output l2_msg_pkg::core_res_t         res_o,
  output l2_msg_pkg::mem_req_t          mem_req_o,
  input  wire l2_msg_pkg::mem_res_t     mem_res_i
);

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    MEM_WAIT,
    RESPOND
  } state_e;

  state_e state_q;

  // ==============================
  // Cache arrays
  // ==============================
  // Valid and LRU are control state, tags and data are not
  logic [l2_geom_pkg::NUM_WAYS-1:0][l2_geom_pkg::NUM_SETS-1:0] valid_q;
  logic [l2_geom_pkg::NUM_SETS-1:0]                            lru_q;
  logic [l2_geom_pkg::TAG_W-1:0]  tag_q  [l2_geom_pkg::NUM_WAYS][l2_geom_pkg::NUM_SETS];
  logic [l2_geom_pkg::DATA_W-1:0] data_q [l2_geom_pkg::NUM_WAYS][l2_geom_pkg::NUM_SETS];

  // Request in service
  l2_msg_pkg::queue_entry_t req_q;

  // Registered outputs
  l2_msg_pkg::core_res_t res_q;
  l2_msg_pkg::mem_req_t  mem_req_q;

  // Address split
  logic [l2_geom_pkg::TAG_W-1:0] req_tag;
  logic [l2_geom_pkg::IDX_W-1:0] req_idx;

  assign req_tag = req_q.addr[l2_geom_pkg::ADDR_W-1:l2_geom_pkg::IDX_W];
  assign req_idx = req_q.addr[l2_geom_pkg::IDX_W-1:0];

  // Lookup results
  logic                           hit;
  logic [l2_geom_pkg::WAY_W-1:0]  hit_way;
  logic [l2_geom_pkg::WAY_W-1:0]  victim_way;
  logic [l2_geom_pkg::DATA_W-1:0] hit_data;

  // Array update controls
  logic                          rd_hit;
  logic                          wr_hit;
  logic                          fill;
  logic                          touch;
  logic [l2_geom_pkg::WAY_W-1:0] touch_way;

  // ==============================
  // Tag compare and victim choice
  // ==============================
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < l2_geom_pkg::NUM_WAYS; w++) begin
      if (valid_q[w][req_idx] && (tag_q[w][req_idx] == req_tag)) begin
        hit     = 1'b1;
        hit_way = w[l2_geom_pkg::WAY_W-1:0];
      end
    end
  end

  assign hit_data = data_q[hit_way][req_idx];

  // LRU way unless a way is still invalid, lowest invalid way wins
  always_comb begin
    victim_way = lru_q[req_idx];
    for (int w = l2_geom_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][req_idx]) begin
        victim_way = w[l2_geom_pkg::WAY_W-1:0];
      end
    end
  end

  assign rd_hit = (state_q == LOOKUP) && !req_q.we && hit;
  assign wr_hit = (state_q == LOOKUP) && req_q.we && hit;
  // Read miss refill, write misses do not allocate
  assign fill   = (state_q == MEM_WAIT) && mem_res_i.valid && !req_q.we;

  // Line that becomes most recently used
  assign touch     = rd_hit || wr_hit || fill;
  assign touch_way = fill ? victim_way : hit_way;

  // Take the head in the same cycle it is seen
  assign pop_o = (state_q == IDLE) && head_vld_i;

  // ==============================
  // Payload updates
  // ==============================
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      req_q <= head_i;
    end
    if (fill) begin
      tag_q[victim_way][req_idx]  <= req_tag;
      data_q[victim_way][req_idx] <= mem_res_i.rdata;
    end
    // Write hit keeps the line coherent with memory
    if (wr_hit) begin
      data_q[hit_way][req_idx] <= req_q.wdata;
    end
  end

  // ==============================
  // FSM and control state
  // ==============================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      valid_q   <= '0;
      lru_q     <= '0;
      res_q     <= '0;
      mem_req_q <= '0;
    end else begin
      // Both strobes last one cycle
      res_q.valid     <= 1'b0;
      mem_req_q.valid <= 1'b0;

      // LRU bit names the way to evict next
      if (touch) begin
        lru_q[req_idx] <= ~touch_way;
      end
      if (fill) begin
        valid_q[victim_way][req_idx] <= 1'b1;
      end

      case (state_q)
        IDLE: begin
          if (head_vld_i) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (rd_hit) begin
            res_q   <= '{valid: 1'b1, port: req_q.port, id: req_q.id, rdata: hit_data};
            state_q <= RESPOND;
          end else begin
            // Read miss or any write goes to memory
            mem_req_q <= '{valid: 1'b1, we: req_q.we, addr: req_q.addr, wdata: req_q.wdata};
            state_q   <= MEM_WAIT;
          end
        end
        MEM_WAIT: begin
          if (mem_res_i.valid) begin
            res_q.valid <= 1'b1;
            res_q.port  <= req_q.port;
            res_q.id    <= req_q.id;
            // Writes echo their own data
            res_q.rdata <= req_q.we ? req_q.wdata : mem_res_i.rdata;
            state_q     <= RESPOND;
          end
        end
        RESPOND: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign res_o     = res_q;
  assign mem_req_o = mem_req_q;

endmodule

`default_nettype wire

//--- src/l2_res_router.sv
// L2 response router (result stage)
// Registers each core completion and steers it to the port it came from
`timescale 1ns/1ps
`default_nettype none

module l2_res_router (
  input  wire logic                                          clk_i,
  input  wire logic                                          arst_n_i,
  input  wire l2_msg_pkg::core_res_t                         core_res_i,
  output l2_msg_pkg::port_res_t [l2_geom_pkg::NUM_PORTS-1:0] res_o
);

  // One output register per port
  l2_msg_pkg::port_res_t [l2_geom_pkg::NUM_PORTS-1:0] res_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_q <= '0;
    end else begin
      // Responses are single-cycle pulses
      for (int p = 0; p < l2_geom_pkg::NUM_PORTS; p++) begin
        res_q[p].valid <= 1'b0;
      end
      // Port field comes from the queue tag
      if (core_res_i.valid) begin
        res_q[core_res_i.port].valid <= 1'b1;
        res_q[core_res_i.port].id    <= core_res_i.id;
        res_q[core_res_i.port].rdata <= core_res_i.rdata;
      end
    end
  end

  assign res_o = res_q;

endmodule

`default_nettype wire

//--- src/l2_bank.sv
// L2 cache bank top
// Dual-port request queue feeding a single-ported cache core and a response router
`timescale 1ns/1ps
`default_nettype none

module l2_bank (
  input  wire logic                                               clk_i,
  input  wire logic                                               arst_n_i,
  // Port side
  input  wire l2_msg_pkg::port_req_t [l2_geom_pkg::NUM_PORTS-1:0] req_i,
  output logic [l2_geom_pkg::NUM_PORTS-1:0]                       rdy_o,
  output l2_msg_pkg::port_res_t [l2_geom_pkg::NUM_PORTS-1:0]      res_o,
  // Memory side
  output l2_msg_pkg::mem_req_t                                    mem_req_o,
  input  wire l2_msg_pkg::mem_res_t                               mem_res_i
);

  // ==============================
  // Stage links
  // ==============================
  // Queue head to core
  l2_msg_pkg::queue_entry_t head;
  logic                     head_vld;
  logic                     pop;

  // Core completion to router
  l2_msg_pkg::core_res_t core_res;

  // Decode stage
  l2_req_queue u_req_queue (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_i),
    .rdy_o      (rdy_o),
    .head_o     (head),
    .head_vld_o (head_vld),
    .pop_i      (pop)
  );

  // Execute stage
  l2_cache_core u_cache_core (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .head_i     (head),
    .head_vld_i (head_vld),
    .pop_o      (pop),
    .res_o      (core_res),
    .mem_req_o  (mem_req_o),
    .mem_res_i  (mem_res_i)
  );

  // Result stage
  l2_res_router u_res_router (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .core_res_i (core_res),
    .res_o      (res_o)
  );

endmodule

`default_nettype wire

//--- testbench/l2_mem_model.sv
// Backing memory model for the L2 bank
// Serves one access at a time and answers after a latency set by the testbench
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic [3:0]           lat_i,
  input  wire l2_msg_pkg::mem_req_t mem_req_i,
  output l2_msg_pkg::mem_res_t      mem_res_o
);

  // Full word address space
  logic [l2_geom_pkg::DATA_W-1:0] mem [2**l2_geom_pkg::ADDR_W];

  logic                  pend_q;
  logic [3:0]            cnt_q;
  l2_msg_pkg::mem_res_t  res_q;

  // Fill pattern built from the whole address
  initial begin
    for (int a = 0; a < 2**l2_geom_pkg::ADDR_W; a++) begin
      mem[a] = {~a[15:0], a[15:0] ^ 16'h3c5a};
    end
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= 1'b0;
      cnt_q  <= '0;
      res_q  <= '0;
    end else begin
      res_q.valid <= 1'b0;
      if (mem_req_i.valid) begin
        // Latency latched with the access
        pend_q <= 1'b1;
        cnt_q  <= lat_i;
        if (mem_req_i.we) begin
          mem[mem_req_i.addr] <= mem_req_i.wdata;
        end else begin
          res_q.rdata <= mem[mem_req_i.addr];
        end
      end else if (pend_q) begin
        if (cnt_q <= 4'd1) begin
          res_q.valid <= 1'b1;
          pend_q      <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 4'd1;
        end
      end
    end
  end

  assign mem_res_o = res_q;

endmodule

`default_nettype wire

//--- testbench/l2_bank_props.sv
// L2 bank port properties
// Response exclusivity, ready ordering, single memory access and reset values
`timescale 1ns/1ps
`default_nettype none

module l2_bank_props (
  input wire logic                                              clk_i,
  input wire logic                                              arst_n_i,
  input wire logic [l2_geom_pkg::NUM_PORTS-1:0]                 rdy_o,
  input wire l2_msg_pkg::port_res_t [l2_geom_pkg::NUM_PORTS-1:0] res_o,
  input wire l2_msg_pkg::mem_req_t                              mem_req_o,
  input wire l2_msg_pkg::mem_res_t                              mem_res_i
);

  // Memory access in flight
  logic busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (mem_req_o.valid) begin
      busy_q <= 1'b1;
    end else if (mem_res_i.valid) begin
      busy_q <= 1'b0;
    end
  end

  // A response goes to one port only
  one_port_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(res_o[0].valid && res_o[1].valid))
    else $error("Response valid on both ports in the same cycle");

  // Port 1 needs more free slots than port 0
  rdy_order_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rdy_o[1] |-> rdy_o[0])
    else $error("Port 1 ready while port 0 is not");

  single_access_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o.valid |-> !busy_q)
    else $error("Memory strobe issued while an access is outstanding");

  // First edge out of reset still shows reset values
  reset_vals_a: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> (!res_o[0].valid && !res_o[1].valid && !mem_req_o.valid
                         && (rdy_o == 2'b11)))
    else $error("Outputs not at reset values after reset");

endmodule

bind l2_bank l2_bank_props u_bank_props (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .rdy_o     (rdy_o),
  .res_o     (res_o),
  .mem_req_o (mem_req_o),
  .mem_res_i (mem_res_i)
);

`default_nettype wire

//--- testbench/l2_bank_tb.sv
// L2 bank testbench
// Directed and random two-port traffic checked against a shadow memory
`timescale 1ns/1ps
`default_nettype none

module l2_bank_tb;

  logic                                              clk_i;
  logic                                              arst_n_i;
  l2_msg_pkg::port_req_t [l2_geom_pkg::NUM_PORTS-1:0] req;
  logic [l2_geom_pkg::NUM_PORTS-1:0]                 rdy;
  l2_msg_pkg::port_res_t [l2_geom_pkg::NUM_PORTS-1:0] res;
  l2_msg_pkg::mem_req_t                              mem_req;
  l2_msg_pkg::mem_res_t                              mem_res;
  logic [3:0]                                        lat;

  // ==============================
  // Reference state
  // ==============================
  logic [l2_geom_pkg::DATA_W-1:0] shadow [logic [l2_geom_pkg::ADDR_W-1:0]];
  l2_msg_pkg::port_res_t          exp_res [l2_geom_pkg::NUM_PORTS][$];
  l2_msg_pkg::mem_req_t           exp_wr [$];
  l2_msg_pkg::mem_req_t           last_rd;
  int                             rd_strobes;
  logic [31:0]                    rng;
  bit                             saw_full;

  l2_bank uut (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req),
    .rdy_o     (rdy),
    .res_o     (res),
    .mem_req_o (mem_req),
    .mem_res_i (mem_res)
  );

  l2_mem_model u_mem (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .lat_i     (lat),
    .mem_req_i (mem_req),
    .mem_res_o (mem_res)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Memory contents before any write
  function automatic logic [31:0] init_word(logic [15:0] addr);
    return {~addr, addr ^ 16'h3c5a};
  endfunction

  // Expected read data at acceptance time
  function automatic logic [31:0] ref_read(logic [15:0] addr);
    return shadow.exists(addr) ? shadow[addr] : init_word(addr);
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_res(int p, l2_msg_pkg::port_res_t got, l2_msg_pkg::port_res_t exp);
    if (got.id !== exp.id) begin
      fail_run($sformatf("Mismatch res_o[%0d].id got %h expected %h", p, got.id, exp.id));
    end
    if (got.rdata !== exp.rdata) begin
      fail_run($sformatf("Mismatch res_o[%0d].rdata got %h expected %h",
                         p, got.rdata, exp.rdata));
    end
  endtask

  // Write data only matters for writes
  task automatic check_mem(l2_msg_pkg::mem_req_t got, l2_msg_pkg::mem_req_t exp);
    if (got.we !== exp.we) begin
      fail_run($sformatf("Mismatch mem_req_o.we got %h expected %h", got.we, exp.we));
    end
    if (got.addr !== exp.addr) begin
      fail_run($sformatf("Mismatch mem_req_o.addr got %h expected %h", got.addr, exp.addr));
    end
    if (exp.we && (got.wdata !== exp.wdata)) begin
      fail_run($sformatf("Mismatch mem_req_o.wdata got %h expected %h",
                         got.wdata, exp.wdata));
    end
  endtask

  // Shadow memory follows acceptance order
  task automatic record_accept(int p);
    l2_msg_pkg::port_res_t exp;
    exp.valid = 1'b1;
    exp.id    = req[p].id;
    if (req[p].we) begin
      shadow[req[p].addr] = req[p].wdata;
      exp.rdata = req[p].wdata;
      exp_wr.push_back('{valid: 1'b1, we: 1'b1, addr: req[p].addr, wdata: req[p].wdata});
    end else begin
      exp.rdata = ref_read(req[p].addr);
    end
    exp_res[p].push_back(exp);
  endtask

  // ==============================
  // Monitor and compare
  // ==============================
  // Accepts, responses and memory strobes seen at the falling edge
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (!rdy[0]) begin
        saw_full = 1'b1;
      end
      for (int p = 0; p < l2_geom_pkg::NUM_PORTS; p++) begin
        if (req[p].valid && rdy[p]) begin
          record_accept(p);
        end
      end
      for (int p = 0; p < l2_geom_pkg::NUM_PORTS; p++) begin
        if (res[p].valid) begin
          if (exp_res[p].size() == 0) begin
            fail_run($sformatf("Response on port %0d with no request outstanding", p));
          end
          check_res(p, res[p], exp_res[p].pop_front());
        end
      end
      if (mem_req.valid && mem_req.we) begin
        if (exp_wr.size() == 0) begin
          fail_run("Memory write issued with no write request outstanding");
        end
        check_mem(mem_req, exp_wr.pop_front());
      end else if (mem_req.valid) begin
        rd_strobes++;
        last_rd = mem_req;
      end
    end
  end

  // Hold the request until the port is ready ahead of an edge
  task automatic send(int p, logic we, logic [3:0] id, logic [15:0] addr, logic [31:0] wdata);
    int tries;
    tries = 0;
    @(posedge clk_i);
    #1;
    req[p] = '{valid: 1'b1, we: we, id: id, addr: addr, wdata: wdata};
    @(negedge clk_i);
    while (!rdy[p]) begin
      tries++;
      if (tries > 100) begin
        fail_run("Port never became ready for a request");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req[p].valid = 1'b0;
  endtask

  task automatic wait_drain(int limit);
    int cycles;
    cycles = 0;
    while (exp_res[0].size() + exp_res[1].size() + exp_wr.size() != 0) begin
      cycles++;
      if (cycles > limit) begin
        fail_run("Timed out waiting for outstanding responses");
      end
      @(negedge clk_i);
    end
  endtask

  // Random cycles on both ports where flooding keeps every valid high
  task automatic drive_random(int cycles, bit flood);
    logic [31:0] r;
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk_i);
      #1;
      if (!flood) begin
        r   = next_rand();
        lat = 4'(r[2:0]) + 4'd1;
      end
      for (int p = 0; p < l2_geom_pkg::NUM_PORTS; p++) begin
        r = next_rand();
        req[p].valid = flood | r[0] | r[3];
        req[p].we    = r[1] & r[2];
        req[p].id    = r[7:4];
        req[p].addr  = 16'(r[13:8]);
        req[p].wdata = next_rand();
      end
    end
    @(posedge clk_i);
    #1;
    req = '0;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int                    base;
    logic [15:0]           seq [5];
    int                    miss [5];
    l2_msg_pkg::mem_req_t  exp_rd;
    rng        = 32'd32;
    rd_strobes = 0;
    saw_full   = 1'b0;
    req        = '0;
    lat        = 4'd2;
    arst_n_i   = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // Cold read misses once and the repeat from port 1 hits
    base = rd_strobes;
    send(0, 1'b0, 4'h5, 16'h0041, '0);
    wait_drain(200);
    if (rd_strobes != base + 1) begin
      fail_run("Cold read did not reach memory exactly once");
    end
    exp_rd = '{valid: 1'b1, we: 1'b0, addr: 16'h0041, wdata: '0};
    check_mem(last_rd, exp_rd);
    send(1, 1'b0, 4'h6, 16'h0041, '0);
    wait_drain(200);
    if (rd_strobes != base + 1) begin
      fail_run("Repeated read went to memory instead of hitting");
    end

    // Write through then read back on both ports
    send(0, 1'b1, 4'h7, 16'h0041, 32'hcafe_0041);
    wait_drain(200);
    send(1, 1'b0, 4'h8, 16'h0041, '0);
    send(0, 1'b0, 4'h9, 16'h0041, '0);
    wait_drain(200);

    // A B A C B on set 3 where C evicts B
    seq  = '{16'h0103, 16'h0203, 16'h0103, 16'h0303, 16'h0203};
    miss = '{1, 1, 0, 1, 1};
    for (int i = 0; i < 5; i++) begin
      base = rd_strobes;
      send(i % 2, 1'b0, 4'(i), seq[i], '0);
      wait_drain(200);
      if (rd_strobes != base + miss[i]) begin
        fail_run($sformatf("LRU step %0d went to memory the wrong number of times", i));
      end
      if (miss[i] == 1) begin
        exp_rd.addr = seq[i];
        check_mem(last_rd, exp_rd);
      end
    end

    drive_random(300, 1'b0);
    wait_drain(3000);

    // Flood with slow memory so the queue fills
    lat      = 4'd8;
    saw_full = 1'b0;
    drive_random(150, 1'b1);
    wait_drain(3000);
    if (!saw_full) begin
      fail_run("Ready never dropped while the queue was flooded");
    end

    // Queue is empty once every response is in
    if (rdy !== {l2_geom_pkg::NUM_PORTS{1'b1}}) begin
      fail_run($sformatf("Mismatch rdy_o got %h expected %h",
                         rdy, {l2_geom_pkg::NUM_PORTS{1'b1}}));
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- all.f
src/l2_geom_pkg.sv
src/l2_msg_pkg.sv
src/l2_req_queue.sv
src/l2_cache_core.sv
src/l2_res_router.sv
src/l2_bank.sv
testbench/l2_mem_model.sv
testbench/l2_bank_props.sv
testbench/l2_bank_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the L2 bank testbench with Verilator and run it
# Exit status is nonzero on a failed build or a failed run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module l2_bank_tb -f all.f -o l2_bank_sim &&
./obj_dir/l2_bank_sim || exit 1
